// File: print_macros.svh
`ifndef PRINT_MACROS_SVH
`define PRINT_MACROS_SVH

// AXI4-Lite address width in bits
`define PRINT_ADDR_W 4

// register byte offsets
`define PRINT_REG_DATA   4'h0
`define PRINT_REG_CMD    4'h4
`define PRINT_REG_STATUS 4'h8

// uart bit period in clock cycles
`define PRINT_CLKS_PER_BIT 16

// characters in a word print: 8 hex digits plus the underscore
`define PRINT_WORD_CHARS 9

`endif

// File: print_pkg.sv
`default_nettype none

`include "print_macros.svh"

package print_pkg;

    typedef logic [31:0] word_t;                   // value handed over for printing
    typedef logic [7:0] char_t;                    // one character toward the uart
    typedef logic [`PRINT_ADDR_W-1:0] axi_addr_t;  // AXI4-Lite byte address

    typedef enum logic [1:0] {
        FMT_IDLE,
        FMT_LOAD,   // word and mode latched, first character prepared
        FMT_SEND,   // character offered to the transmitter
        FMT_WAIT    // done pulse cycle
    } fmt_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

`default_nettype wire

// File: print_regs.sv
`default_nettype none

`include "print_macros.svh"

module print_regs (
    input  logic                 clk,
    input  logic                 rstn,
    input  print_pkg::axi_addr_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  print_pkg::axi_addr_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready,
    input  logic                 done,
    output logic                 start,
    output logic                 mode,
    output print_pkg::word_t     data
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic             wr_hs;
    logic             busy;
    print_pkg::word_t data_q;
    logic [31:0]      rd_mux;

    // address and data are taken together, one write at a time
    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign data    = data_q;
    assign rresp   = RESP_OKAY;   // every read is answered

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
            data_q <= '0;
            start  <= 1'b0;
            mode   <= 1'b0;
            busy   <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= RESP_OKAY;
                case (awaddr)
                    `PRINT_REG_DATA: begin
                        for (int i = 0; i < 4; i++) begin
                            if (wstrb[i]) data_q[8*i +: 8] <= wdata[8*i +: 8];
                        end
                    end
                    `PRINT_REG_CMD: begin
                        if (busy || start) begin
                            bresp <= RESP_SLVERR;   // print in progress, command dropped
                        end else begin
                            start <= 1'b1;
                            mode  <= wdata[0];
                        end
                    end
                    default: ;   // status and holes ignore writes
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        case (araddr)
            `PRINT_REG_DATA:   rd_mux = data_q;
            `PRINT_REG_STATUS: rd_mux = {31'b0, busy};
            default:           rd_mux = '0;   // cmd is write only
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (arvalid && arready) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (!rvalid) begin
            arready <= 1'b1;   // first cycle out of reset
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) rdata <= rd_mux;
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        bvalid && !bready |=> bvalid);

    // a second print must never begin on top of a running one
    a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
        start |-> !busy);

endmodule

`default_nettype wire

// File: print_fmt.sv
`default_nettype none

`include "print_macros.svh"

module print_fmt (
    input  logic             clk,
    input  logic             rstn,
    input  logic             start,
    input  logic             mode,       // 0 byte, 1 word
    input  print_pkg::word_t data,
    input  logic             chr_ready,
    output print_pkg::char_t chr,
    output logic             chr_valid,
    output logic             done
);

    print_pkg::fmt_state_e state;
    print_pkg::word_t      word_q;       // shifts left one nibble per hex digit
    print_pkg::word_t      word_n;
    logic                  mode_q;
    logic [3:0]            rem;          // characters left after the current one
    logic                  chr_hs;
    logic                  next_chr;

    function automatic print_pkg::char_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};   // '0'..'9'
        end
        return 8'h37 + {4'h0, nib};       // 'A'..'F'
    endfunction

    // character for the current position, msb nibble sits at the top of w
    function automatic print_pkg::char_t fmt_char(input logic m,
                                                  input print_pkg::word_t w,
                                                  input logic [3:0] r);
        if (!m) begin
            return w[7:0];
        end
        if (r == 4'd4) begin
            return 8'h5f;   // underscore between the halves
        end
        return hex_char(w[31:28]);
    endfunction

    assign chr_hs   = chr_valid && chr_ready;
    assign next_chr = (state == print_pkg::FMT_SEND) && chr_hs && (rem != 4'd0);
    // the underscore consumes no nibble
    assign word_n   = (rem == 4'd4) ? word_q : {word_q[27:0], 4'h0};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= print_pkg::FMT_IDLE;
            rem       <= '0;
            chr_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                print_pkg::FMT_IDLE: begin
                    if (start) begin
                        rem   <= mode ? 4'(`PRINT_WORD_CHARS - 1) : 4'd0;
                        state <= print_pkg::FMT_LOAD;
                    end
                end
                print_pkg::FMT_LOAD: begin
                    chr_valid <= 1'b1;
                    state     <= print_pkg::FMT_SEND;
                end
                print_pkg::FMT_SEND: begin
                    if (chr_hs) begin
                        if (rem == 4'd0) begin
                            chr_valid <= 1'b0;
                            done      <= 1'b1;
                            state     <= print_pkg::FMT_WAIT;
                        end else begin
                            rem <= rem - 4'd1;   // valid stays up for the next one
                        end
                    end
                end
                print_pkg::FMT_WAIT: state <= print_pkg::FMT_IDLE;
                default:             state <= print_pkg::FMT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == print_pkg::FMT_IDLE && start) begin
            word_q <= data;
            mode_q <= mode;
        end else if (next_chr) begin
            word_q <= word_n;
        end

        if (state == print_pkg::FMT_LOAD) begin
            chr <= fmt_char(mode_q, word_q, rem);
        end else if (next_chr) begin
            chr <= fmt_char(mode_q, word_n, rem - 4'd1);
        end
    end

    a_chr_stable: assert property (@(posedge clk) disable iff (!rstn)
        chr_valid && !chr_ready |=> chr_valid && $stable(chr));

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

`include "print_macros.svh"

module uart_tx (
    input  logic             clk,
    input  logic             rstn,
    input  logic             chr_valid,
    input  print_pkg::char_t chr,
    output logic             chr_ready,
    output logic             txd
);

    localparam int CNT_W = $clog2(`PRINT_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PRINT_CLKS_PER_BIT - 1);

    print_pkg::tx_state_e state;
    logic [CNT_W-1:0]     cnt;       // baud counter
    logic [2:0]           bit_idx;
    print_pkg::char_t     shreg;     // lsb is the bit on the line
    logic                 bit_end;
    logic                 take;

    assign chr_ready = (state == print_pkg::TX_IDLE);
    assign take      = chr_ready && chr_valid;
    assign bit_end   = (cnt == CNT_LAST);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= print_pkg::TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                print_pkg::TX_IDLE: begin
                    cnt <= '0;
                    if (chr_valid) begin
                        txd   <= 1'b0;   // start bit
                        state <= print_pkg::TX_START;
                    end
                end
                print_pkg::TX_START: begin
                    if (bit_end) begin
                        txd     <= shreg[0];
                        bit_idx <= '0;
                        state   <= print_pkg::TX_DATA;
                    end
                end
                print_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1;   // stop bit
                            state <= print_pkg::TX_STOP;
                        end else begin
                            txd     <= shreg[1];
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                print_pkg::TX_STOP: begin
                    if (bit_end) state <= print_pkg::TX_IDLE;
                end
                default: state <= print_pkg::TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            shreg <= chr;
        end else if (state == print_pkg::TX_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    a_idle_mark: assert property (@(posedge clk) disable iff (!rstn)
        state == print_pkg::TX_IDLE |-> txd);

endmodule

`default_nettype wire

// File: print_top.sv
`default_nettype none

module print_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  print_pkg::axi_addr_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  print_pkg::axi_addr_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready,
    output logic                 txd
);

    logic             start;
    logic             mode;
    print_pkg::word_t data;
    logic             done;
    print_pkg::char_t chr;
    logic             chr_valid;
    logic             chr_ready;

    print_regs u_print_regs (
        .clk     (clk),     .rstn    (rstn),
        .awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wstrb   (wstrb),   .wvalid  (wvalid),  .wready (wready),
        .bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
        .araddr  (araddr),  .arvalid (arvalid), .arready (arready),
        .rdata   (rdata),   .rresp   (rresp),   .rvalid  (rvalid),  .rready (rready),
        .done    (done),    .start   (start),   .mode    (mode),    .data   (data)
    );

    print_fmt u_print_fmt (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .mode      (mode),
        .data      (data),
        .chr_ready (chr_ready),
        .chr       (chr),
        .chr_valid (chr_valid),
        .done      (done)
    );

    uart_tx u_uart_tx (
        .clk       (clk),
        .rstn      (rstn),
        .chr_valid (chr_valid),
        .chr       (chr),
        .chr_ready (chr_ready),
        .txd       (txd)
    );

endmodule

`default_nettype wire

// File: tb_uart_rx.sv
`default_nettype none

`include "print_macros.svh"

module tb_uart_rx (
    input logic clk,
    input logic rstn,
    input logic txd
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] rx_q[$];    // received characters, oldest first
    int         frame_errs;

    // txd changes on the rising edge, so every sample is taken on the falling edge
    initial begin
        logic [7:0] shift;
        frame_errs = 0;
        forever begin
            @(negedge clk);
            if (rstn && txd === 1'b0) begin
                repeat (`PRINT_CLKS_PER_BIT / 2) @(negedge clk);   // middle of the start bit
                if (txd !== 1'b0) begin
                    frame_errs++;
                    $display("framing error at %0t: start bit did not hold low", $time);
                end else begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (`PRINT_CLKS_PER_BIT) @(negedge clk);
                        shift[i] = txd;   // lsb first
                    end
                    repeat (`PRINT_CLKS_PER_BIT) @(negedge clk);
                    if (txd !== 1'b1) begin
                        frame_errs++;
                        $display("framing error at %0t: stop bit was not high", $time);
                    end
                    rx_q.push_back(shift);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_print_top.sv
`default_nettype none

`include "print_macros.svh"

module tb_print_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     N_RAND      = 12;
    localparam int     N_PRINTS    = N_RAND + 3;
    localparam int     CHAR_CYCLES = 10 * `PRINT_CLKS_PER_BIT;
    // every print counted as a word print, plus room for reset and register traffic
    localparam longint TIMEOUT_NS  =
        longint'(N_PRINTS) * `PRINT_WORD_CHARS * CHAR_CYCLES * 20 + 200_000;

    logic                 clk;
    logic                 rstn;
    print_pkg::axi_addr_t awaddr;
    logic                 awvalid;
    logic                 awready;
    logic [31:0]          wdata;
    logic [3:0]           wstrb;
    logic                 wvalid;
    logic                 wready;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 bready;
    print_pkg::axi_addr_t araddr;
    logic                 arvalid;
    logic                 arready;
    logic [31:0]          rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    logic                 rready;
    logic                 txd;

    logic [7:0]  exp_q[$];      // model of the character stream
    logic [31:0] data_model;    // model of the DATA register
    int          errors;
    string       hex_digits = "0123456789ABCDEF";

    print_top u_print_top (.*);

    tb_uart_rx u_rx (.clk(clk), .rstn(rstn), .txd(txd));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input logic [31:0] act, input logic [31:0] exp, input string msg);
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, act, exp);
        end
    endtask

    task automatic axi_write(input print_pkg::axi_addr_t addr, input logic [31:0] wd,
                             input logic [3:0] strb, output logic [1:0] resp);
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = wd;
        wstrb   = strb;
        wvalid  = 1'b1;
        #1;
        while (!(awready && wready)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);                  // transfer happened on the rising edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input print_pkg::axi_addr_t addr, output logic [31:0] rd,
                            output logic [1:0] resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) @(negedge clk);
        rd   = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // expected characters of one print, msb nibble first
    task automatic add_expected(input logic [31:0] w, input logic m);
        if (!m) begin
            exp_q.push_back(w[7:0]);
        end else begin
            for (int i = 7; i >= 0; i--) begin
                exp_q.push_back(hex_digits[w[4*i +: 4]]);
                if (i == 4) exp_q.push_back(8'h5f);
            end
        end
    endtask

    task automatic print_value(input logic [31:0] w, input logic m);
        logic [1:0] resp;
        axi_write(`PRINT_REG_DATA, w, 4'hf, resp);
        check(resp, 2'b00, "DATA write response");
        data_model = w;
        axi_write(`PRINT_REG_CMD, {31'b0, m}, 4'hf, resp);
        check(resp, 2'b00, "CMD write response");
        add_expected(w, m);
    endtask

    task automatic wait_idle;
        logic [31:0] st;
        logic [1:0]  resp;
        do begin
            axi_read(`PRINT_REG_STATUS, st, resp);
        end while (st[0]);
    endtask

    // waits for the expected count, then one more character time to catch extras
    task automatic compare_stream(input string msg);
        while (u_rx.rx_q.size() < exp_q.size()) @(negedge clk);
        repeat (CHAR_CYCLES) @(negedge clk);
        check(u_rx.rx_q.size(), exp_q.size(), {msg, " character count"});
        while (exp_q.size() > 0 && u_rx.rx_q.size() > 0) begin
            check(u_rx.rx_q.pop_front(), exp_q.pop_front(), {msg, " character"});
        end
        exp_q.delete();
        u_rx.rx_q.delete();
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] rd;
        logic [3:0]  strb;
        logic [1:0]  resp;
        errors     = 0;
        data_model = '0;
        rstn       = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        void'($urandom(32'hac28_df2e));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        check(bvalid, 1'b0, "bvalid after reset");
        check(rvalid, 1'b0, "rvalid after reset");
        axi_read(`PRINT_REG_STATUS, rd, resp);
        check(rd, 32'h0, "STATUS after reset");
        repeat (CHAR_CYCLES) @(negedge clk);
        check(u_rx.rx_q.size(), 0, "characters after reset");

        for (int i = 0; i < 8; i++) begin
            w    = $urandom();
            strb = $urandom_range(15, 0);
            axi_write(`PRINT_REG_DATA, w, strb, resp);
            check(resp, 2'b00, "DATA write response");
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) data_model[8*b +: 8] = w[8*b +: 8];   // per byte merge
            end
            axi_read(`PRINT_REG_DATA, rd, resp);
            check(rd, data_model, "DATA readback");
            check(resp, 2'b00, "DATA read response");
        end

        print_value($urandom(), 1'b0);
        wait_idle();
        compare_stream("byte print");

        print_value($urandom(), 1'b1);
        axi_read(`PRINT_REG_STATUS, rd, resp);
        check(rd[0], 1'b1, "STATUS busy during word print");
        wait_idle();
        compare_stream("word print");
        axi_read(`PRINT_REG_STATUS, rd, resp);
        check(rd[0], 1'b0, "STATUS idle after word print");

        print_value($urandom(), 1'b1);
        axi_write(`PRINT_REG_CMD, 32'h1, 4'hf, resp);   // lands while busy
        check(resp, 2'b10, "CMD write while busy");
        wait_idle();
        compare_stream("print with dropped CMD");

        for (int i = 0; i < N_RAND; i++) begin
            print_value($urandom(), 1'($urandom_range(1, 0)));
            wait_idle();
        end
        compare_stream("random prints");

        $display("errors: %0d  framing errors: %0d", errors, u_rx.frame_errs);
        if (errors == 0 && u_rx.frame_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
print_pkg.sv
print_regs.sv
print_fmt.sv
uart_tx.sv
print_top.sv
tb_uart_rx.sv
tb_print_top.sv
